// File: verif/rv_backend_stim.txt
// valid inst     pc       we rd expected   (valid 1 issue, 0 bubble, e end of stream)
// registers start at zero, consumers issue five entries after their producer
1 00500093 00000000 1 01 00000005 // addi x1, x0, 5
1 ffd00113 00000004 1 02 fffffffd // addi x2, x0, -3
1 123451b7 00000008 1 03 12345000 // lui x3, 0x12345
1 00001217 0000000c 1 04 0000100c // auipc x4, 0x1
1 008002ef 00000010 1 05 00000014 // jal x5, 8
1 00700013 00000014 0 00 00000000 // addi x0, x0, 7
1 00208333 00000018 1 06 00000002 // add x6, x1, x2
1 402083b3 0000001c 1 07 00000008 // sub x7, x1, x2
1 00317433 00000020 1 08 12345000 // and x8, x2, x3
1 001264b3 00000024 1 09 0000100d // or x9, x4, x1
1 0022c533 00000028 1 0a ffffffe9 // xor x10, x5, x2
1 001125b3 0000002c 1 0b 00000001 // slt x11, x2, x1
1 00609633 00000030 1 0c 00000014 // sll x12, x1, x6
1 001156b3 00000034 1 0d 07ffffff // srl x13, x2, x1
1 0f017713 00000038 1 0e 000000f0 // andi x14, x2, 0xf0
1 1000e793 0000003c 1 0f 00000105 // ori x15, x1, 0x100
1 fff0c813 00000040 1 10 fffffffa // xori x16, x1, -1
1 0060a893 00000044 1 11 00000001 // slti x17, x1, 6
1 00362223 00000048 0 00 00000000 // sw x3, 4(x12)
1 00008967 0000004c 1 12 00000050 // jalr x18, 0(x1)
1 00462983 00000050 1 13 12345000 // lw x19, 4(x12)
1 00100ab3 00000054 1 15 00000005 // add x21, x0, x1
0 00000000 00000000 0 00 00000000 // bubble
0 00000000 00000000 0 00 00000000 // bubble
1 fffffc37 00000060 1 18 fffff000 // lui x24, 0xfffff
1 00198b93 00000064 1 17 12345001 // addi x23, x19, 1
e 00000000 00000000 0 00 00000000 // end of stream

// File: all.f
source/rv_isa_pkg.sv
source/rv_pipe_pkg.sv
source/rv_regfile.sv
source/rv_decode.sv
source/rv_execute.sv
source/rv_memory.sv
source/rv_writeback.sv
source/rv_backend_top.sv
verif/rv_backend_sva.sv
verif/rv_backend_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv_backend_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/10ps
PASS_MSG  ?= PASS: all tests

SOURCES := $(wildcard source/*.sv) $(wildcard verif/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verif/rv_backend_tb.sv
`timescale 1ns/10ps

module rv_backend_tb;

    localparam int    DMEM_WORDS   = 256;
    localparam int    MAX_ENTRIES  = 64;
    localparam int    WORDS_PER    = 6;
    localparam int    PIPE_CYCLES  = 4;
    localparam int    RESET_CYCLES = 10;
    localparam int    MARGIN       = 20;
    localparam string STIM_FILE    = "verif/rv_backend_stim.txt";

    // Tag in the valid column that ends the stream
    localparam logic [31:0] END_TAG = 32'h0000000e;

    logic        clk;
    logic        rst_n_i;
    logic        inst_valid_i;
    logic [31:0] inst_i;
    logic [31:0] pc_i;
    logic        wb_valid_o;
    logic        rf_we_o;
    logic [4:0]  rd_addr_o;
    logic [31:0] wb_data_o;

    // Six words per entry: valid, inst, pc, rf_we, rd, data
    logic [31:0] stim_words [MAX_ENTRIES*WORDS_PER];
    int          n_entries;
    int          n_checks;
    int          n_errors;
    int          cycle_count = 0;
    int          timeout_limit = 0;
    int          pending [$];

    rv_backend_top #(
        .DMEM_WORDS (DMEM_WORDS)
    ) i_dut (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .wb_valid_o   (wb_valid_o),
        .rf_we_o      (rf_we_o),
        .rd_addr_o    (rd_addr_o),
        .wb_data_o    (wb_data_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_count);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic load_stimulus();
        int e;
        $readmemh(STIM_FILE, stim_words);
        e = 0;
        while (e < MAX_ENTRIES && stim_words[e*WORDS_PER] != END_TAG) begin
            e++;
        end
        n_entries = e;
        if (n_entries == 0) begin
            n_errors++;
            $display("No stimulus entries were read from %s", STIM_FILE);
        end
        if (n_entries == MAX_ENTRIES) begin
            n_errors++;
            $display("End marker missing in %s, stream cut at %0d entries",
                     STIM_FILE, MAX_ENTRIES);
        end
    endtask

    task automatic drive_entry(input int e);
        inst_valid_i = stim_words[e*WORDS_PER][0];
        inst_i       = stim_words[e*WORDS_PER+1];
        pc_i         = stim_words[e*WORDS_PER+2];
    endtask

    task automatic drive_bubble();
        inst_valid_i = 1'b0;
        inst_i       = '0;
        pc_i         = '0;
    endtask

    task automatic check_idle(input string where);
        n_checks++;
        if (wb_valid_o !== 1'b0 || rf_we_o !== 1'b0) begin
            n_errors++;
            $display("FAILED t=%0t: %s, wb_valid_o=%b rf_we_o=%b, expected both low",
                     $time, where, wb_valid_o, rf_we_o);
        end
    endtask

    // Compare the writeback outputs with one stimulus entry
    task automatic check_entry(input int e);
        logic        exp_valid;
        logic        exp_we;
        logic [4:0]  exp_rd;
        logic [31:0] exp_data;
        if (e < 0) begin
            check_idle("drain");
        end else begin
            exp_valid = stim_words[e*WORDS_PER][0];
            exp_we    = stim_words[e*WORDS_PER+3][0];
            exp_rd    = stim_words[e*WORDS_PER+4][4:0];
            exp_data  = stim_words[e*WORDS_PER+5];
            n_checks++;
            if (wb_valid_o !== exp_valid) begin
                n_errors++;
                $display("FAILED t=%0t: entry %0d wb_valid_o got %b, expected %b",
                         $time, e, wb_valid_o, exp_valid);
            end
            if (rf_we_o !== exp_we) begin
                n_errors++;
                $display("FAILED t=%0t: entry %0d rf_we_o got %b, expected %b",
                         $time, e, rf_we_o, exp_we);
            end
            // Address and data only matter for a real write
            if (exp_we) begin
                if (rd_addr_o !== exp_rd) begin
                    n_errors++;
                    $display("FAILED t=%0t: entry %0d rd_addr_o got %0d, expected %0d",
                             $time, e, rd_addr_o, exp_rd);
                end
                if (wb_data_o !== exp_data) begin
                    n_errors++;
                    $display("FAILED t=%0t: entry %0d wb_data_o got %h, expected %h",
                             $time, e, wb_data_o, exp_data);
                end
            end
        end
    endtask

    initial begin : main_sequence
        int idx;
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        pc_i         = '0;
        n_checks     = 0;
        n_errors     = 0;
        load_stimulus();
        timeout_limit = n_entries + PIPE_CYCLES + MARGIN;

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_idle("reset");
        end
        rst_n_i = 1'b1;

        // Each result is due four falling edges after its issue
        for (idx = 0; idx < n_entries + PIPE_CYCLES; idx++) begin
            @(negedge clk);
            if (pending.size() == PIPE_CYCLES) begin
                check_entry(pending.pop_front());
            end else begin
                check_idle("after reset");
            end
            if (idx < n_entries) begin
                drive_entry(idx);
                pending.push_back(idx);
            end else begin
                drive_bubble();
                pending.push_back(-1);
            end
        end

        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: verif/rv_backend_sva.sv
`timescale 1ns/10ps

module rv_backend_sva (
    input logic       clk,
    input logic       rst_n_i,
    input logic       wb_valid_i,
    input logic       rf_we_i,
    input logic       rf_we_reg_i,
    input logic [4:0] rd_addr_i
);

    // A registered write enable only travels with its valid bit
    property p_we_implies_valid;
        @(posedge clk) disable iff (!rst_n_i)
            rf_we_reg_i |-> wb_valid_i;
    endproperty

    // x0 writes are dropped in decode
    property p_no_x0_write;
        @(posedge clk) disable iff (!rst_n_i)
            rf_we_i |-> (rd_addr_i != 5'd0);
    endproperty

    property p_known_controls;
        @(posedge clk) disable iff (!rst_n_i)
            !$isunknown({wb_valid_i, rf_we_i});
    endproperty

    a_we_implies_valid: assert property (p_we_implies_valid)
        else $error("registered rf_we high while wb_valid_o is low");

    a_no_x0_write: assert property (p_no_x0_write)
        else $error("rf_we_o high with rd_addr_o equal to zero");

    a_known_controls: assert property (p_known_controls)
        else $error("wb_valid_o or rf_we_o is unknown after reset");

endmodule

bind rv_writeback rv_backend_sva i_sva (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .wb_valid_i  (wb_valid_o),
    .rf_we_i     (rf_we_o),
    .rf_we_reg_i (rf_we_q),
    .rd_addr_i   (rd_addr_o)
);

// File: source/rv_backend_top.sv
`timescale 1ns/10ps

module rv_backend_top #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        inst_valid_i,
    input  logic [31:0]                 inst_i,
    input  logic [rv_isa_pkg::XLEN-1:0] pc_i,
    output logic                        wb_valid_o,
    output logic                        rf_we_o,
    output logic [4:0]                  rd_addr_o,
    output logic [rv_isa_pkg::XLEN-1:0] wb_data_o
);

    // Register file read port
    logic [4:0]                  rs1_addr;
    logic [4:0]                  rs2_addr;
    logic [rv_isa_pkg::XLEN-1:0] rs1_data;
    logic [rv_isa_pkg::XLEN-1:0] rs2_data;

    // Decode stage register
    logic                        d_valid;
    logic [rv_isa_pkg::XLEN-1:0] d_pc;
    logic [rv_isa_pkg::XLEN-1:0] d_op_a;
    logic [rv_isa_pkg::XLEN-1:0] d_op_b;
    logic [rv_isa_pkg::XLEN-1:0] d_store_data;
    rv_pipe_pkg::alu_op_e        d_alu_op;
    logic                        d_mem_rd;
    logic                        d_mem_wr;
    logic                        d_rf_we;
    rv_pipe_pkg::wb_sel_e        d_wb_sel;
    logic [4:0]                  d_rd;

    // Execute stage register
    logic                        e_valid;
    logic [rv_isa_pkg::XLEN-1:0] e_pc;
    logic [rv_isa_pkg::XLEN-1:0] e_result;
    logic [rv_isa_pkg::XLEN-1:0] e_store_data;
    logic                        e_mem_rd;
    logic                        e_mem_wr;
    logic                        e_rf_we;
    rv_pipe_pkg::wb_sel_e        e_wb_sel;
    logic [4:0]                  e_rd;

    // Memory stage register
    logic                        m_valid;
    logic [rv_isa_pkg::XLEN-1:0] m_pc;
    logic [rv_isa_pkg::XLEN-1:0] m_result;
    logic [rv_isa_pkg::XLEN-1:0] m_rdata;
    logic                        m_rf_we;
    rv_pipe_pkg::wb_sel_e        m_wb_sel;
    logic [4:0]                  m_rd;

    rv_decode i_decode (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .valid_o      (d_valid),
        .pc_o         (d_pc),
        .op_a_o       (d_op_a),
        .op_b_o       (d_op_b),
        .store_data_o (d_store_data),
        .alu_op_o     (d_alu_op),
        .mem_rd_o     (d_mem_rd),
        .mem_wr_o     (d_mem_wr),
        .rf_we_o      (d_rf_we),
        .wb_sel_o     (d_wb_sel),
        .rd_o         (d_rd)
    );

    // Written from the writeback outputs
    rv_regfile i_regfile (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (rf_we_o),
        .rd_addr_i  (rd_addr_o),
        .rd_data_i  (wb_data_o)
    );

    rv_execute i_execute (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .valid_i      (d_valid),
        .pc_i         (d_pc),
        .op_a_i       (d_op_a),
        .op_b_i       (d_op_b),
        .store_data_i (d_store_data),
        .alu_op_i     (d_alu_op),
        .mem_rd_i     (d_mem_rd),
        .mem_wr_i     (d_mem_wr),
        .rf_we_i      (d_rf_we),
        .wb_sel_i     (d_wb_sel),
        .rd_i         (d_rd),
        .valid_o      (e_valid),
        .pc_o         (e_pc),
        .result_o     (e_result),
        .store_data_o (e_store_data),
        .mem_rd_o     (e_mem_rd),
        .mem_wr_o     (e_mem_wr),
        .rf_we_o      (e_rf_we),
        .wb_sel_o     (e_wb_sel),
        .rd_o         (e_rd)
    );

    rv_memory #(
        .DMEM_WORDS (DMEM_WORDS)
    ) i_memory (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .valid_i      (e_valid),
        .pc_i         (e_pc),
        .result_i     (e_result),
        .store_data_i (e_store_data),
        .mem_rd_i     (e_mem_rd),
        .mem_wr_i     (e_mem_wr),
        .rf_we_i      (e_rf_we),
        .wb_sel_i     (e_wb_sel),
        .rd_i         (e_rd),
        .valid_o      (m_valid),
        .pc_o         (m_pc),
        .result_o     (m_result),
        .dmem_rdata_o (m_rdata),
        .rf_we_o      (m_rf_we),
        .wb_sel_o     (m_wb_sel),
        .rd_o         (m_rd)
    );

    rv_writeback i_writeback (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .valid_i      (m_valid),
        .pc_i         (m_pc),
        .result_i     (m_result),
        .dmem_rdata_i (m_rdata),
        .rf_we_i      (m_rf_we),
        .wb_sel_i     (m_wb_sel),
        .rd_i         (m_rd),
        .wb_valid_o   (wb_valid_o),
        .rf_we_o      (rf_we_o),
        .rd_addr_o    (rd_addr_o),
        .wb_data_o    (wb_data_o)
    );

endmodule

// File: source/rv_writeback.sv
`timescale 1ns/10ps

module rv_writeback (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        valid_i,
    input  logic [rv_isa_pkg::XLEN-1:0] pc_i,
    input  logic [rv_isa_pkg::XLEN-1:0] result_i,
    input  logic [rv_isa_pkg::XLEN-1:0] dmem_rdata_i,
    input  logic                        rf_we_i,
    input  rv_pipe_pkg::wb_sel_e        wb_sel_i,
    input  logic [4:0]                  rd_i,
    output logic                        wb_valid_o,
    output logic                        rf_we_o,
    output logic [4:0]                  rd_addr_o,
    output logic [rv_isa_pkg::XLEN-1:0] wb_data_o
);

    logic                        valid_q;
    logic                        rf_we_q;
    rv_pipe_pkg::wb_sel_e        wb_sel_q;
    logic [rv_isa_pkg::XLEN-1:0] pc_q;
    logic [rv_isa_pkg::XLEN-1:0] result_q;
    logic [rv_isa_pkg::XLEN-1:0] rdata_q;
    logic [rv_isa_pkg::XLEN-1:0] pc_plus4;
    logic [4:0]                  rd_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q  <= 1'b0;
            rf_we_q  <= 1'b0;
            wb_sel_q <= rv_pipe_pkg::WB_NONE;
        end else begin
            valid_q  <= valid_i;
            rf_we_q  <= rf_we_i;
            wb_sel_q <= wb_sel_i;
        end
    end

    always_ff @(posedge clk) begin
        pc_q     <= pc_i;
        result_q <= result_i;
        rdata_q  <= dmem_rdata_i;
        rd_q     <= rd_i;
    end

    // Link value for JAL and JALR
    assign pc_plus4 = pc_q + 32'd4;

    always_comb begin
        case (wb_sel_q)
            rv_pipe_pkg::WB_PC4:  wb_data_o = pc_plus4;
            rv_pipe_pkg::WB_ALU:  wb_data_o = result_q;
            rv_pipe_pkg::WB_LOAD: wb_data_o = rdata_q;
            default:              wb_data_o = '0;
        endcase
    end

    assign wb_valid_o = valid_q;
    assign rf_we_o    = valid_q & rf_we_q;
    assign rd_addr_o  = rd_q;

endmodule

// File: source/rv_memory.sv
`timescale 1ns/10ps

module rv_memory #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        valid_i,
    input  logic [rv_isa_pkg::XLEN-1:0] pc_i,
    input  logic [rv_isa_pkg::XLEN-1:0] result_i,
    input  logic [rv_isa_pkg::XLEN-1:0] store_data_i,
    input  logic                        mem_rd_i,
    input  logic                        mem_wr_i,
    input  logic                        rf_we_i,
    input  rv_pipe_pkg::wb_sel_e        wb_sel_i,
    input  logic [4:0]                  rd_i,
    output logic                        valid_o,
    output logic [rv_isa_pkg::XLEN-1:0] pc_o,
    output logic [rv_isa_pkg::XLEN-1:0] result_o,
    output logic [rv_isa_pkg::XLEN-1:0] dmem_rdata_o,
    output logic                        rf_we_o,
    output rv_pipe_pkg::wb_sel_e        wb_sel_o,
    output logic [4:0]                  rd_o
);

    localparam int AW = $clog2(DMEM_WORDS);

    logic [rv_isa_pkg::XLEN-1:0] mem [DMEM_WORDS];
    logic [AW-1:0]               word_idx;

    // Word address, wraps at the depth (a power of two)
    assign word_idx = result_i[AW+1:2];

    always_ff @(posedge clk) begin
        if (valid_i && mem_wr_i) begin
            mem[word_idx] <= store_data_i;
        end
        if (valid_i && mem_rd_i) begin
            dmem_rdata_o <= mem[word_idx];
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o  <= 1'b0;
            rf_we_o  <= 1'b0;
            wb_sel_o <= rv_pipe_pkg::WB_NONE;
        end else begin
            valid_o  <= valid_i;
            rf_we_o  <= rf_we_i;
            wb_sel_o <= wb_sel_i;
        end
    end

    always_ff @(posedge clk) begin
        pc_o     <= pc_i;
        result_o <= result_i;
        rd_o     <= rd_i;
    end

endmodule

// File: source/rv_execute.sv
`timescale 1ns/10ps

module rv_execute (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        valid_i,
    input  logic [rv_isa_pkg::XLEN-1:0] pc_i,
    input  logic [rv_isa_pkg::XLEN-1:0] op_a_i,
    input  logic [rv_isa_pkg::XLEN-1:0] op_b_i,
    input  logic [rv_isa_pkg::XLEN-1:0] store_data_i,
    input  rv_pipe_pkg::alu_op_e        alu_op_i,
    input  logic                        mem_rd_i,
    input  logic                        mem_wr_i,
    input  logic                        rf_we_i,
    input  rv_pipe_pkg::wb_sel_e        wb_sel_i,
    input  logic [4:0]                  rd_i,
    output logic                        valid_o,
    output logic [rv_isa_pkg::XLEN-1:0] pc_o,
    output logic [rv_isa_pkg::XLEN-1:0] result_o,
    output logic [rv_isa_pkg::XLEN-1:0] store_data_o,
    output logic                        mem_rd_o,
    output logic                        mem_wr_o,
    output logic                        rf_we_o,
    output rv_pipe_pkg::wb_sel_e        wb_sel_o,
    output logic [4:0]                  rd_o
);

    logic [rv_isa_pkg::XLEN-1:0] alu_res;

    always_comb begin
        case (alu_op_i)
            rv_pipe_pkg::ALU_ADD:    alu_res = op_a_i + op_b_i;
            rv_pipe_pkg::ALU_SUB:    alu_res = op_a_i - op_b_i;
            rv_pipe_pkg::ALU_AND:    alu_res = op_a_i & op_b_i;
            rv_pipe_pkg::ALU_OR:     alu_res = op_a_i | op_b_i;
            rv_pipe_pkg::ALU_XOR:    alu_res = op_a_i ^ op_b_i;
            rv_pipe_pkg::ALU_SLT:    alu_res = {{(rv_isa_pkg::XLEN-1){1'b0}},
                                                $signed(op_a_i) < $signed(op_b_i)};
            // Shift amount is the low five bits
            rv_pipe_pkg::ALU_SLL:    alu_res = op_a_i << op_b_i[4:0];
            rv_pipe_pkg::ALU_SRL:    alu_res = op_a_i >> op_b_i[4:0];
            rv_pipe_pkg::ALU_PASS_B: alu_res = op_b_i;
            default:                 alu_res = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o  <= 1'b0;
            mem_rd_o <= 1'b0;
            mem_wr_o <= 1'b0;
            rf_we_o  <= 1'b0;
            wb_sel_o <= rv_pipe_pkg::WB_NONE;
        end else begin
            valid_o  <= valid_i;
            mem_rd_o <= mem_rd_i;
            mem_wr_o <= mem_wr_i;
            rf_we_o  <= rf_we_i;
            wb_sel_o <= wb_sel_i;
        end
    end

    // Result doubles as the memory address
    always_ff @(posedge clk) begin
        pc_o         <= pc_i;
        result_o     <= alu_res;
        store_data_o <= store_data_i;
        rd_o         <= rd_i;
    end

endmodule

// File: source/rv_decode.sv
`timescale 1ns/10ps

module rv_decode (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            inst_valid_i,
    input  logic [31:0]                     inst_i,
    input  logic [rv_isa_pkg::XLEN-1:0]     pc_i,
    input  logic [rv_isa_pkg::XLEN-1:0]     rs1_data_i,
    input  logic [rv_isa_pkg::XLEN-1:0]     rs2_data_i,
    output logic [4:0]                      rs1_addr_o,
    output logic [4:0]                      rs2_addr_o,
    output logic                            valid_o,
    output logic [rv_isa_pkg::XLEN-1:0]     pc_o,
    output logic [rv_isa_pkg::XLEN-1:0]     op_a_o,
    output logic [rv_isa_pkg::XLEN-1:0]     op_b_o,
    output logic [rv_isa_pkg::XLEN-1:0]     store_data_o,
    output rv_pipe_pkg::alu_op_e            alu_op_o,
    output logic                            mem_rd_o,
    output logic                            mem_wr_o,
    output logic                            rf_we_o,
    output rv_pipe_pkg::wb_sel_e            wb_sel_o,
    output logic [4:0]                      rd_o
);

    rv_isa_pkg::rv_inst_u              inst;
    logic [6:0]                        opcode;
    logic [rv_isa_pkg::XLEN-1:0]       imm;
    logic [rv_isa_pkg::XLEN-1:0]       op_a;
    logic [rv_isa_pkg::XLEN-1:0]       op_b;
    rv_pipe_pkg::alu_op_e              alu_op;
    rv_pipe_pkg::wb_sel_e              wb_sel;
    logic                              writes_rd;

    assign inst       = inst_i;
    assign opcode     = inst.r.opcode;
    assign rs1_addr_o = inst.r.rs1;
    assign rs2_addr_o = inst.r.rs2;

    // Sign-extended immediate, I format unless the opcode says otherwise
    always_comb begin
        case (opcode)
            rv_isa_pkg::OPC_LUI,
            rv_isa_pkg::OPC_AUIPC: imm = {inst.u.imm31_12, 12'b0};
            rv_isa_pkg::OPC_STORE: imm = {{20{inst.s.imm11_5[6]}}, inst.s.imm11_5, inst.s.imm4_0};
            rv_isa_pkg::OPC_JAL:   imm = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
                                          inst.j.imm11, inst.j.imm10_1, 1'b0};
            default:               imm = {{20{inst.i.imm11_0[11]}}, inst.i.imm11_0};
        endcase
    end

    // Operand A is zero for LUI, the PC for AUIPC and JAL
    always_comb begin
        case (opcode)
            rv_isa_pkg::OPC_LUI:   op_a = '0;
            rv_isa_pkg::OPC_AUIPC,
            rv_isa_pkg::OPC_JAL:   op_a = pc_i;
            default:               op_a = rs1_data_i;
        endcase
    end

    assign op_b = (opcode == rv_isa_pkg::OPC_OP) ? rs2_data_i : imm;

    always_comb begin
        alu_op = rv_pipe_pkg::ALU_ADD;
        if (opcode == rv_isa_pkg::OPC_LUI) begin
            alu_op = rv_pipe_pkg::ALU_PASS_B;
        end else if (opcode == rv_isa_pkg::OPC_OP || opcode == rv_isa_pkg::OPC_OPIMM) begin
            case (inst.r.funct3)
                rv_isa_pkg::F3_ADD: begin
                    // Only the register form has sub
                    if (opcode == rv_isa_pkg::OPC_OP && inst.r.funct7 == rv_isa_pkg::F7_SUB) begin
                        alu_op = rv_pipe_pkg::ALU_SUB;
                    end
                end
                rv_isa_pkg::F3_SLL: alu_op = rv_pipe_pkg::ALU_SLL;
                rv_isa_pkg::F3_SLT: alu_op = rv_pipe_pkg::ALU_SLT;
                rv_isa_pkg::F3_XOR: alu_op = rv_pipe_pkg::ALU_XOR;
                rv_isa_pkg::F3_SRL: alu_op = rv_pipe_pkg::ALU_SRL;
                rv_isa_pkg::F3_OR:  alu_op = rv_pipe_pkg::ALU_OR;
                rv_isa_pkg::F3_AND: alu_op = rv_pipe_pkg::ALU_AND;
                default:            alu_op = rv_pipe_pkg::ALU_ADD;
            endcase
        end
    end

    always_comb begin
        writes_rd = 1'b1;
        case (opcode)
            rv_isa_pkg::OPC_LOAD:  wb_sel = rv_pipe_pkg::WB_LOAD;
            rv_isa_pkg::OPC_JAL,
            rv_isa_pkg::OPC_JALR:  wb_sel = rv_pipe_pkg::WB_PC4;
            rv_isa_pkg::OPC_LUI,
            rv_isa_pkg::OPC_AUIPC,
            rv_isa_pkg::OPC_OP,
            rv_isa_pkg::OPC_OPIMM: wb_sel = rv_pipe_pkg::WB_ALU;
            default: begin
                wb_sel    = rv_pipe_pkg::WB_NONE;
                writes_rd = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o  <= 1'b0;
            mem_rd_o <= 1'b0;
            mem_wr_o <= 1'b0;
            rf_we_o  <= 1'b0;
            wb_sel_o <= rv_pipe_pkg::WB_NONE;
        end else begin
            valid_o  <= inst_valid_i;
            mem_rd_o <= inst_valid_i && opcode == rv_isa_pkg::OPC_LOAD;
            mem_wr_o <= inst_valid_i && opcode == rv_isa_pkg::OPC_STORE;
            // Writes to x0 are dropped here
            rf_we_o  <= inst_valid_i && writes_rd && inst.r.rd != 5'd0;
            wb_sel_o <= wb_sel;
        end
    end

    always_ff @(posedge clk) begin
        pc_o         <= pc_i;
        op_a_o       <= op_a;
        op_b_o       <= op_b;
        store_data_o <= rs2_data_i;
        alu_op_o     <= alu_op;
        rd_o         <= inst.r.rd;
    end

endmodule

// File: source/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic [4:0]                  rs1_addr_i,
    input  logic [4:0]                  rs2_addr_i,
    output logic [rv_isa_pkg::XLEN-1:0] rs1_data_o,
    output logic [rv_isa_pkg::XLEN-1:0] rs2_data_o,
    input  logic                        we_i,
    input  logic [4:0]                  rd_addr_i,
    input  logic [rv_isa_pkg::XLEN-1:0] rd_data_i
);

    logic [rv_isa_pkg::XLEN-1:0] regs [32];

    // x0 always reads as zero
    assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs[rs2_addr_i];

    // Architectural state starts cleared
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i) begin
            regs[rd_addr_i] <= rd_data_i;
        end
    end

endmodule

// File: source/rv_pipe_pkg.sv
package rv_pipe_pkg;

    // ALU operation chosen in decode
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_SLL    = 4'd6,
        ALU_SRL    = 4'd7,
        ALU_PASS_B = 4'd8
    } alu_op_e;

    // Source of register-file write data
    typedef enum logic [1:0] {
        WB_NONE = 2'b00,
        WB_PC4  = 2'b01,
        WB_ALU  = 2'b10,
        WB_LOAD = 2'b11
    } wb_sel_e;

endpackage

// File: source/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int XLEN = 32;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_OP    = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_JAL   = 7'b1101111;
    localparam logic [6:0] OPC_JALR  = 7'b1100111;

    // funct3 shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // funct7 that turns add into sub
    localparam logic [6:0] F7_SUB = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // J immediate bits are scrambled in the encoding
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        u_fmt_t u;
        j_fmt_t j;
    } rv_inst_u;

endpackage
